//--- tile_pkg.sv
/* Bus, flit and address map definitions shared by every block of the tile
   Sizes are fixed here; only one NoC virtual channel exists */
`default_nettype none

package tile_pkg;

   typedef struct packed {
      logic [31:0] adr;                              // Byte address
      logic [31:0] dat;                              // Write data
      logic [3:0]  sel;                              // Byte lane enables
      logic        we;                               // Write when set
      logic        cyc;                              // Cycle in progress
      logic        stb;                              // Request strobe
   } bus_req_t;

   typedef struct packed {
      logic [31:0] dat;                              // Read data
      logic        ack;                              // Normal end of transfer
      logic        err;                              // Error end of transfer
   } bus_rsp_t;

   typedef enum logic [1:0] {
      FLIT_PAYLOAD = 2'd0,
      FLIT_HEAD    = 2'd1,
      FLIT_TAIL    = 2'd2,
      FLIT_SINGLE  = 2'd3
   } flit_type_e;

   typedef struct packed {
      flit_type_e  ftype;                            // Bits 33:32 on the link
      logic [31:0] data;
   } flit_t;

   // Value doubles as the slave index on the bus
   typedef enum logic [1:0] {
      SLV_RAM  = 2'd0,
      SLV_ROM  = 2'd1,
      SLV_NA   = 2'd2,
      SLV_NONE = 2'd3
   } slave_e;

   localparam logic [31:0] RAM_BASE    = 32'h0000_0000;
   localparam logic [31:0] ROM_BASE    = 32'hF000_0000;
   localparam logic [31:0] NA_BASE     = 32'hE000_0000;
   localparam logic [31:0] REGION_MASK = 32'hF000_0000; // Upper nibble picks region

   localparam int RAM_WORDS  = 256;
   localparam int RAM_AW     = $clog2(RAM_WORDS);
   localparam int ROM_WORDS  = 16;
   localparam int ROM_AW     = $clog2(ROM_WORDS);
   localparam int FIFO_DEPTH = 4;
   localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

   localparam logic [2:0] NA_TX_BASE = 3'd0;         // Offsets 0..3 send, type = offset
   localparam logic [2:0] NA_RX_DATA = 3'd4;         // Pops the receive queue
   localparam logic [2:0] NA_STATUS  = 3'd5;         // Rx count and tx full

endpackage

`default_nettype wire

//--- tile_bus.sv
/* Shared bus of the tile: round-robin between two masters, three slaves
   Masters hold cyc/stb until a single ack or err cycle; no retry or bursts
   Unmapped addresses get err one cycle after the grant */
`timescale 1ns/1ps
`default_nettype none

module tile_bus (
   input  wire                    clk_i,
   input  wire                    rst_n_i,
   input  tile_pkg::bus_req_t     m_req_i [2],
   output tile_pkg::bus_rsp_t     m_rsp_o [2],
   output tile_pkg::bus_req_t     s_req_o [3],
   input  tile_pkg::bus_rsp_t     s_rsp_i [3]
);

   typedef enum logic {
      IDLE,
      BUSY
   } state_e;

   state_e               state_q;
   logic                 gnt_q;                      // Index of granted master
   logic                 last_q;                     // Master served last
   logic                 err_q;                      // Decode error response
   logic [1:0]           mreq;
   logic                 pick;
   logic                 busy;
   logic                 done;
   tile_pkg::bus_req_t   greq;
   tile_pkg::bus_rsp_t   srsp;
   tile_pkg::slave_e     slv;

   assign mreq[0] = m_req_i[0].cyc & m_req_i[0].stb;
   assign mreq[1] = m_req_i[1].cyc & m_req_i[1].stb;
   assign busy    = (state_q == BUSY);
   assign greq    = m_req_i[gnt_q];                  // Granted request, held stable

   always_comb begin
      if (mreq[0] && mreq[1]) begin
         pick = ~last_q;                             // Both waiting, other one wins
      end else begin
         pick = mreq[1];
      end
   end

   always_comb begin
      case (greq.adr & tile_pkg::REGION_MASK)
         tile_pkg::RAM_BASE: slv = tile_pkg::SLV_RAM;
         tile_pkg::ROM_BASE: slv = tile_pkg::SLV_ROM;
         tile_pkg::NA_BASE:  slv = tile_pkg::SLV_NA;
         default:            slv = tile_pkg::SLV_NONE;
      endcase
   end

   always_comb begin
      for (int i = 0; i < 3; i++) begin
         s_req_o[i]     = greq;                      // Address and data to all
         s_req_o[i].cyc = busy & greq.cyc & (slv == tile_pkg::slave_e'(i));
         s_req_o[i].stb = busy & greq.stb & (slv == tile_pkg::slave_e'(i));
      end
   end

   always_comb begin
      case (slv)
         tile_pkg::SLV_RAM: srsp = s_rsp_i[0];
         tile_pkg::SLV_ROM: srsp = s_rsp_i[1];
         tile_pkg::SLV_NA:  srsp = s_rsp_i[2];
         default:           srsp = '{dat: 32'h0, ack: 1'b0, err: err_q};
      endcase
   end

   assign done = busy & (srsp.ack | srsp.err);

   // Response goes back to the granted master only
   assign m_rsp_o[0] = (busy && !gnt_q) ? srsp : '0;
   assign m_rsp_o[1] = (busy && gnt_q) ? srsp : '0;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q <= IDLE;
         gnt_q   <= 1'b0;
         last_q  <= 1'b0;
         err_q   <= 1'b0;
      end else begin
         err_q <= busy & (slv == tile_pkg::SLV_NONE) & ~err_q; // One cycle only
         case (state_q)
            IDLE: begin
               if (|mreq) begin
                  state_q <= BUSY;
                  gnt_q   <= pick;
                  last_q  <= pick;
               end
            end
            BUSY: begin
               if (done) begin
                  state_q <= IDLE;                   // Release on ack or err
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   // Only the strobed slave may answer
   a_rsp_strobed: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !((s_rsp_i[0].ack || s_rsp_i[0].err) && !s_req_o[0].stb) &&
      !((s_rsp_i[1].ack || s_rsp_i[1].err) && !s_req_o[1].stb) &&
      !((s_rsp_i[2].ack || s_rsp_i[2].err) && !s_req_o[2].stb))
      else $error("slave answered without a strobe");

   a_ack_err: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(m_rsp_o[0].ack && m_rsp_o[0].err) && !(m_rsp_o[1].ack && m_rsp_o[1].err))
      else $error("ack and err together on a master response");

endmodule

`default_nettype wire

//--- tile_sram.sv
/* Word RAM of RAM_WORDS words behind the tile bus, no init contents
   Upper address bits beyond the RAM size wrap around */
`timescale 1ns/1ps
`default_nettype none

module tile_sram (
   input  wire                 clk_i,
   input  wire                 rst_n_i,
   input  tile_pkg::bus_req_t  req_i,
   output tile_pkg::bus_rsp_t  rsp_o
);

   logic [31:0]                mem [tile_pkg::RAM_WORDS];
   logic [tile_pkg::RAM_AW-1:0] idx;
   logic                       req_v;
   logic                       ack_q;
   logic [31:0]                rdat_q;

   assign idx   = req_i.adr[tile_pkg::RAM_AW+1:2];  // Word address
   assign req_v = req_i.cyc & req_i.stb & ~ack_q;   // Not yet answered

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= req_v;
      end
   end

   always_ff @(posedge clk_i) begin
      if (req_v && req_i.we) begin
         for (int b = 0; b < 4; b++) begin
            if (req_i.sel[b]) begin
               mem[idx][b*8 +: 8] <= req_i.dat[b*8 +: 8]; // Selected lanes only
            end
         end
      end
      rdat_q <= mem[idx];                            // Full word read
   end

   assign rsp_o = '{dat: rdat_q, ack: ack_q, err: 1'b0};

   // Ack lands while the bus still holds the request
   a_ack_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rsp_o.ack |-> (req_i.cyc && req_i.stb))
      else $error("sram ack without a held request");

endmodule

`default_nettype wire

//--- tile_bootrom.sv
/* Fixed boot table of ROM_WORDS words, address wraps modulo the table size
   Writes end with err and change nothing */
`timescale 1ns/1ps
`default_nettype none

module tile_bootrom (
   input  wire                 clk_i,
   input  wire                 rst_n_i,
   input  tile_pkg::bus_req_t  req_i,
   output tile_pkg::bus_rsp_t  rsp_o
);

   logic [tile_pkg::ROM_AW-1:0] idx;
   logic [31:0]                rom_dat;
   logic                       req_v;
   logic                       ack_q;
   logic                       err_q;
   logic [31:0]                dat_q;

   assign idx   = req_i.adr[tile_pkg::ROM_AW+1:2];
   assign req_v = req_i.cyc & req_i.stb & ~ack_q & ~err_q;

   always_comb begin
      case (idx)
         4'h0: rom_dat = 32'h1800_0000;              // Clear r0 high half
         4'h1: rom_dat = 32'hA800_0000;              // Clear r0 low half
         4'h2: rom_dat = 32'h1820_0000;              // Stack top high
         4'h3: rom_dat = 32'hA821_03FC;              // Stack top at end of RAM
         4'h4: rom_dat = 32'h1860_E000;              // Adapter base
         4'h5: rom_dat = 32'h8483_0014;              // Poll status
         4'h6: rom_dat = 32'hA484_0007;              // Mask rx count
         4'h7: rom_dat = 32'hBC04_0000;
         4'h8: rom_dat = 32'h13FF_FFFD;              // Loop while nothing received
         4'h9: rom_dat = 32'h1500_0000;              // Delay slot
         4'hA: rom_dat = 32'h84A3_0010;              // Read entry address
         4'hB: rom_dat = 32'h4400_2800;              // Jump to it
         4'hC: rom_dat = 32'h1500_0000;
         4'hD: rom_dat = 32'h0000_0000;
         4'hE: rom_dat = 32'hDEAD_BEEF;              // Table end marker
         default: rom_dat = 32'hB007_C0DE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= req_v & ~req_i.we;
         err_q <= req_v & req_i.we;                  // Read-only
      end
   end

   always_ff @(posedge clk_i) begin
      dat_q <= rom_dat;
   end

   assign rsp_o = '{dat: dat_q, ack: ack_q, err: err_q};

endmodule

`default_nettype wire

//--- tile_fifo.sv
/* Flit FIFO of FIFO_DEPTH entries with a combinational head output
   Push when full and pop when empty are dropped silently */
`timescale 1ns/1ps
`default_nettype none

module tile_fifo (
   input  wire                         clk_i,
   input  wire                         rst_n_i,
   input  wire                         push_i,
   input  tile_pkg::flit_t             data_i,
   input  wire                         pop_i,
   output tile_pkg::flit_t             data_o,
   output logic                        empty_o,
   output logic                        full_o,
   output logic [tile_pkg::FIFO_AW:0]  count_o
);

   tile_pkg::flit_t              mem [tile_pkg::FIFO_DEPTH];
   logic [tile_pkg::FIFO_AW-1:0] wptr_q;
   logic [tile_pkg::FIFO_AW-1:0] rptr_q;
   logic [tile_pkg::FIFO_AW:0]   cnt_q;
   logic                         do_push;
   logic                         do_pop;

   assign empty_o = (cnt_q == 0);
   assign full_o  = (cnt_q == tile_pkg::FIFO_DEPTH);
   assign count_o = cnt_q;
   assign do_push = push_i & ~full_o;
   assign do_pop  = pop_i & ~empty_o;
   assign data_o  = mem[rptr_q];                     // Head entry

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wptr_q <= '0;
         rptr_q <= '0;
         cnt_q  <= '0;
      end else begin
         wptr_q <= wptr_q + do_push;                 // Wraps at depth
         rptr_q <= rptr_q + do_pop;
         cnt_q  <= cnt_q + do_push - do_pop;
      end
   end

   always_ff @(posedge clk_i) begin
      if (do_push) begin
         mem[wptr_q] <= data_i;
      end
   end

   // Count stays within depth and matches the pointer distance
   a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (cnt_q <= tile_pkg::FIFO_DEPTH) &&
      (wptr_q == rptr_q + cnt_q[tile_pkg::FIFO_AW-1:0]))
      else $error("fifo count and pointers disagree");

endmodule

`default_nettype wire

//--- tile_na.sv
/* Message-passing adapter: bus writes become NoC flits, received flits wait in a queue
   Send writes stall while the send queue is full; rx read of an empty queue gets err
   Undefined offsets and wrong-direction accesses also end with err */
`timescale 1ns/1ps
`default_nettype none

module tile_na (
   input  wire                 clk_i,
   input  wire                 rst_n_i,
   input  tile_pkg::bus_req_t  req_i,
   output tile_pkg::bus_rsp_t  rsp_o,
   input  tile_pkg::flit_t     noc_in_flit_i,
   input  wire                 noc_in_valid_i,
   output logic                noc_in_ready_o,
   output tile_pkg::flit_t     noc_out_flit_o,
   output logic                noc_out_valid_o,
   input  wire                 noc_out_ready_i,
   output logic                irq_o
);

   logic [2:0]                 ofs;
   logic [2:0]                 tx_ofs;
   logic                       req_v;
   logic                       is_tx;
   logic                       is_rx;
   logic                       is_stat;
   logic                       tx_push;
   logic                       tx_full;
   logic                       tx_empty;
   logic                       rx_pop;
   logic                       rx_full;
   logic                       rx_empty;
   logic [tile_pkg::FIFO_AW:0] rx_cnt;
   tile_pkg::flit_t            tx_flit;
   tile_pkg::flit_t            rx_flit;
   logic                       ack_q;
   logic                       err_q;
   logic [31:0]                dat_q;

   assign ofs     = req_i.adr[4:2];                  // Word offset in region
   assign tx_ofs  = ofs - tile_pkg::NA_TX_BASE;
   assign req_v   = req_i.cyc & req_i.stb & ~ack_q & ~err_q;
   assign is_tx   = (ofs >= tile_pkg::NA_TX_BASE) && (ofs < tile_pkg::NA_RX_DATA);
   assign is_rx   = (ofs == tile_pkg::NA_RX_DATA);
   assign is_stat = (ofs == tile_pkg::NA_STATUS);

   assign tx_flit = '{ftype: tile_pkg::flit_type_e'(tx_ofs[1:0]), data: req_i.dat};
   assign tx_push = req_v & req_i.we & is_tx & ~tx_full;
   assign rx_pop  = req_v & ~req_i.we & is_rx & ~rx_empty;

   tile_fifo u_tx_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .push_i  (tx_push),
      .data_i  (tx_flit),
      .pop_i   (noc_out_ready_i),                    // Moves when valid and ready
      .data_o  (noc_out_flit_o),
      .empty_o (tx_empty),
      .full_o  (tx_full),
      .count_o ()
   );

   tile_fifo u_rx_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .push_i  (noc_in_valid_i & noc_in_ready_o),
      .data_i  (noc_in_flit_i),
      .pop_i   (rx_pop),
      .data_o  (rx_flit),
      .empty_o (rx_empty),
      .full_o  (rx_full),
      .count_o (rx_cnt)
   );

   assign noc_out_valid_o = ~tx_empty;
   assign noc_in_ready_o  = ~rx_full;                // Back-pressure into the NoC
   assign irq_o           = ~rx_empty;               // Level while messages wait

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
         if (req_v) begin
            if (is_tx && req_i.we) begin
               ack_q <= ~tx_full;                    // Held off until a slot frees
            end else if (is_rx && !req_i.we) begin
               ack_q <= ~rx_empty;
               err_q <= rx_empty;                    // Nothing to read
            end else if (is_stat && !req_i.we) begin
               ack_q <= 1'b1;
            end else begin
               err_q <= 1'b1;
            end
         end
      end
   end

   // Sampled in the request cycle, before the pop takes effect
   always_ff @(posedge clk_i) begin
      if (is_rx) begin
         dat_q <= rx_flit.data;                      // Type bits dropped
      end else begin
         dat_q <= {23'h0, tx_full, 5'h0, rx_cnt};
      end
   end

   assign rsp_o = '{dat: dat_q, ack: ack_q, err: err_q};

endmodule

`default_nettype wire

//--- compute_tile.sv
/* Compute tile without a core: the instruction and data bus ports face outward
   Slaves are RAM at 0x0, adapter at 0xE, boot ROM at 0xF (upper nibble) */
`timescale 1ns/1ps
`default_nettype none

module compute_tile (
   input  wire                 clk_i,
   input  wire                 rst_n_i,
   input  tile_pkg::bus_req_t  ibus_req_i,
   output tile_pkg::bus_rsp_t  ibus_rsp_o,
   input  tile_pkg::bus_req_t  dbus_req_i,
   output tile_pkg::bus_rsp_t  dbus_rsp_o,
   input  tile_pkg::flit_t     noc_in_flit_i,
   input  wire                 noc_in_valid_i,
   output logic                noc_in_ready_o,
   output tile_pkg::flit_t     noc_out_flit_o,
   output logic                noc_out_valid_o,
   input  wire                 noc_out_ready_i,
   output logic                irq_o
);

   tile_pkg::bus_req_t  m_req [2];
   tile_pkg::bus_rsp_t  m_rsp [2];
   tile_pkg::bus_req_t  s_req [3];
   tile_pkg::bus_rsp_t  s_rsp [3];

   assign m_req[0]   = ibus_req_i;                   // Master 0 instruction port
   assign m_req[1]   = dbus_req_i;                   // Master 1 data port
   assign ibus_rsp_o = m_rsp[0];
   assign dbus_rsp_o = m_rsp[1];

   tile_bus u_bus (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .m_req_i (m_req),
      .m_rsp_o (m_rsp),
      .s_req_o (s_req),
      .s_rsp_i (s_rsp)
   );

   tile_sram u_ram (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (s_req[0]),                           // SLV_RAM
      .rsp_o   (s_rsp[0])
   );

   tile_bootrom u_bootrom (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (s_req[1]),                           // SLV_ROM
      .rsp_o   (s_rsp[1])
   );

   tile_na u_na (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .req_i           (s_req[2]),                   // SLV_NA
      .rsp_o           (s_rsp[2]),
      .noc_in_flit_i   (noc_in_flit_i),
      .noc_in_valid_i  (noc_in_valid_i),
      .noc_in_ready_o  (noc_in_ready_o),
      .noc_out_flit_o  (noc_out_flit_o),
      .noc_out_valid_o (noc_out_valid_o),
      .noc_out_ready_i (noc_out_ready_i),
      .irq_o           (irq_o)                       // Message interrupt
   );

endmodule

`default_nettype wire

//--- tb_compute_tile.sv
/* Self-checking testbench for compute_tile, run from the project root
   Operations come from compute_tile_golden.txt; every wait gives up after max_wait cycles
   Port 0 is the instruction bus, port 1 the data bus */
`timescale 1ns/1ps
`default_nettype none

module tb_compute_tile;

   logic               clk;
   logic               rst_n;
   tile_pkg::bus_req_t ibus_req;
   tile_pkg::bus_req_t dbus_req;
   tile_pkg::bus_rsp_t ibus_rsp;
   tile_pkg::bus_rsp_t dbus_rsp;
   tile_pkg::flit_t    flit_in;
   logic               vin;
   logic               rdy_in;
   tile_pkg::flit_t    flit_out;
   logic               vout;
   logic               rdy_out;
   logic               irq;
   tile_pkg::flit_t    early_q [$];                  // Flits that left during a stalled write
   logic [31:0]        rng;
   int                 max_wait = 64;
   int                 passes;
   int                 fails;
   int                 tchecks;
   int                 tfails;
   int                 last_port = -1;               // Port that finished last, -1 unknown

   compute_tile compute_tile_i (
      .clk_i           (clk),
      .rst_n_i         (rst_n),
      .ibus_req_i      (ibus_req),
      .ibus_rsp_o      (ibus_rsp),
      .dbus_req_i      (dbus_req),
      .dbus_rsp_o      (dbus_rsp),
      .noc_in_flit_i   (flit_in),
      .noc_in_valid_i  (vin),
      .noc_in_ready_o  (rdy_in),
      .noc_out_flit_o  (flit_out),
      .noc_out_valid_o (vout),
      .noc_out_ready_i (rdy_out),
      .irq_o           (irq)
   );

   always #50 clk = ~clk;                            // 100 ns period

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic tile_pkg::bus_rsp_t rsp_of(input int port);
      return (port == 0) ? ibus_rsp : dbus_rsp;
   endfunction

   task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
      tchecks++;
      if (got !== exp) begin
         fails++;
         tfails++;
         $display("FAIL %0t ns: %0s, got %h expected %h", $time, msg, got, exp);
      end else begin
         passes++;
      end
   endtask

   task automatic timeout_fail(input string msg);
      fails++;
      tfails++;
      $display("timeout after %0d cycles: %0s", max_wait, msg);
   endtask

   task automatic drive_req(input int port, input tile_pkg::bus_req_t r);
      if (port == 0) begin
         ibus_req <= r;
      end else begin
         dbus_req <= r;
      end
   endtask

   // Holds the request until ack or err, lat counts cycles from first presentation
   task automatic bus_access(input int port, input logic we, input logic [31:0] adr,
                             input logic [31:0] dat, input logic [3:0] sel,
                             output tile_pkg::bus_rsp_t rsp, output int lat);
      tile_pkg::bus_rsp_t r;
      int                 n;
      logic               done;
      n    = 0;
      done = 1'b0;
      r    = '0;
      @(posedge clk);
      drive_req(port, '{adr: adr, dat: dat, sel: sel, we: we, cyc: 1'b1, stb: 1'b1});
      while (!done && n < max_wait) begin
         @(negedge clk);
         r = rsp_of(port);
         if (r.ack || r.err) begin
            done = 1'b1;
         end else begin
            n++;
         end
      end
      if (!done) begin
         timeout_fail($sformatf("port %0d got no ack or err at %h", port, adr));
      end else begin
         last_port = port;
      end
      rsp = r;
      lat = n;
      @(posedge clk);
      drive_req(port, '0);                           // Drop after the response cycle
   endtask

   task automatic write_word(input int port, input logic [31:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel);
      tile_pkg::bus_rsp_t r;
      int                 lat;
      bus_access(port, 1'b1, adr, dat, sel, r, lat);
      check(r.ack, 1'b1, $sformatf("write ack at %h", adr));
      check(lat, 2, $sformatf("write latency at %h", adr));
   endtask

   task automatic read_word(input int port, input logic [31:0] adr, input logic [31:0] exp);
      tile_pkg::bus_rsp_t r;
      int                 lat;
      bus_access(port, 1'b0, adr, 32'h0, 4'hf, r, lat);
      check(r.ack, 1'b1, $sformatf("read ack at %h", adr));
      check(r.dat, exp, $sformatf("read data at %h", adr));
      check(lat, 2, $sformatf("read latency at %h", adr));
   endtask

   task automatic expect_error(input int port, input logic [31:0] adr, input logic we);
      tile_pkg::bus_rsp_t r;
      int                 lat;
      bus_access(port, we, adr, 32'h0, 4'hf, r, lat);
      check(r.err, 1'b1, $sformatf("err at %h", adr));
      check(lat, 2, $sformatf("err latency at %h", adr));
   endtask

   task automatic parallel_read(input logic [31:0] a0, input logic [31:0] e0,
                                input logic [31:0] a1, input logic [31:0] e1);
      tile_pkg::bus_rsp_t r0;
      tile_pkg::bus_rsp_t r1;
      int                 l0;
      int                 l1;
      int                 winner;
      winner = (last_port < 0) ? -1 : 1 - last_port; // Round robin skips the last one served
      fork
         bus_access(0, 1'b0, a0, 32'h0, 4'hf, r0, l0);
         bus_access(1, 1'b0, a1, 32'h0, 4'hf, r1, l1);
      join
      check(r0.dat, e0, "parallel read data on port 0");
      check(r1.dat, e1, "parallel read data on port 1");
      check(r0.ack & r1.ack, 1'b1, "both parallel reads acked");
      check((l0 == 2) ^ (l1 == 2), 1'b1, "exactly one port served without waiting");
      check(((l0 > l1) ? l0 : l1) <= 5, 1'b1, "waiting port served right after the other");
      if (winner >= 0) begin
         check((winner == 0) ? l0 : l1, 2, "round-robin winner served first");
      end
   endtask

   task automatic inject(input logic [1:0] t, input logic [31:0] d);
      int   n;
      logic done;
      n    = 0;
      done = 1'b0;
      @(posedge clk);
      flit_in <= '{ftype: tile_pkg::flit_type_e'(t), data: d};
      vin     <= 1'b1;
      while (!done && n < max_wait) begin
         @(negedge clk);
         if (rdy_in) begin
            done = 1'b1;                             // Moves on the next edge
         end else begin
            n++;
         end
      end
      if (!done) begin
         timeout_fail("NoC input never became ready");
      end
      @(posedge clk);
      vin <= 1'b0;
   endtask

   // Raises ready until one flit has moved
   task automatic take_flit(output tile_pkg::flit_t f, output logic ok);
      int n;
      n  = 0;
      ok = 1'b0;
      f  = '0;
      @(posedge clk);
      rdy_out <= 1'b1;
      while (!ok && n < max_wait) begin
         @(negedge clk);
         if (vout) begin
            f  = flit_out;
            ok = 1'b1;
         end else begin
            n++;
         end
      end
      if (!ok) begin
         timeout_fail("no flit on the NoC output");
      end
      @(posedge clk);
      rdy_out <= 1'b0;
   endtask

   task automatic expect_flit(input logic [1:0] t, input logic [31:0] d);
      tile_pkg::flit_t f;
      logic            ok;
      repeat (rng % 4) @(posedge clk);               // Random ready stall
      rng = xorshift(rng);
      if (early_q.size() > 0) begin
         f  = early_q.pop_front();
         ok = 1'b1;
      end else begin
         take_flit(f, ok);
      end
      if (ok) begin
         check({30'h0, f.ftype}, {30'h0, t}, "outgoing flit type");
         check(f.data, d, "outgoing flit data");
      end
   endtask

   // Send write into a full queue, ack must wait for one flit to leave
   task automatic stalled_write(input int port, input logic [31:0] adr, input logic [31:0] dat);
      tile_pkg::bus_rsp_t r;
      tile_pkg::flit_t    f;
      logic               held;
      logic               ok;
      logic               done;
      int                 n;
      held = 1'b0;
      done = 1'b0;
      n    = 0;
      @(posedge clk);
      drive_req(port, '{adr: adr, dat: dat, sel: 4'hf, we: 1'b1, cyc: 1'b1, stb: 1'b1});
      repeat (6) begin
         @(negedge clk);
         r    = rsp_of(port);
         held = held | r.ack | r.err;
      end
      check(held, 1'b0, "send write answered while send queue full");
      take_flit(f, ok);
      if (ok) begin
         early_q.push_back(f);
      end
      while (!done && n < max_wait) begin
         @(negedge clk);
         r = rsp_of(port);
         if (r.ack || r.err) begin
            done = 1'b1;
         end else begin
            n++;
         end
      end
      if (!done) begin
         timeout_fail("stalled send write never acked after a flit left");
      end else begin
         check(r.ack, 1'b1, "stalled send write ack");
         last_port = port;
      end
      @(posedge clk);
      drive_req(port, '0);
   endtask

   task automatic end_test(input logic [8*32-1:0] name);
      $display("test %0s finished: %0d checks, %0d failed", name, tchecks, tfails);
      tchecks = 0;
      tfails  = 0;
   endtask

   initial begin
      int               fd;
      int               code;
      logic             more;
      logic [7:0]       op;
      logic [31:0]      a;
      logic [31:0]      b;
      logic [31:0]      c;
      logic [31:0]      d;
      logic [8*32-1:0]  name;
      logic [8*256-1:0] line;
      clk      = 1'b0;
      rst_n    = 1'b0;
      ibus_req = '0;
      dbus_req = '0;
      flit_in  = '0;
      vin      = 1'b0;
      rdy_out  = 1'b0;                               // Output held back unless a flit is taken
      rng      = 32'd80153;
      passes   = 0;
      fails    = 0;
      tchecks  = 0;
      tfails   = 0;
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check(ibus_rsp.ack | ibus_rsp.err | dbus_rsp.ack | dbus_rsp.err, 1'b0, "bus idle");
      check(vout, 1'b0, "noc out valid after reset");
      check(rdy_in, 1'b1, "noc in ready after reset");
      check(irq, 1'b0, "irq after reset");
      end_test("reset_state");

      fd   = $fopen("compute_tile_golden.txt", "r");
      more = (fd != 0);
      if (fd == 0) begin
         $display("could not open compute_tile_golden.txt");
         fails++;
      end
      while (more) begin
         code = $fscanf(fd, " %c", op);
         more = (code == 1);
         if (more) begin
            case (op)
               "#": code = $fgets(line, fd);         // Comment line
               "W": begin
                  code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
                  write_word(a, b, c, d[3:0]);
               end
               "R": begin
                  code = $fscanf(fd, "%h %h %h", a, b, c);
                  read_word(a, b, c);
               end
               "E": begin
                  code = $fscanf(fd, "%h %h %h", a, b, c);
                  expect_error(a, b, c[0]);
               end
               "P": begin
                  code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
                  parallel_read(a, b, c, d);
               end
               "I": begin
                  code = $fscanf(fd, "%h %h", a, b);
                  inject(a[1:0], b);
               end
               "O": begin
                  code = $fscanf(fd, "%h %h", a, b);
                  expect_flit(a[1:0], b);
               end
               "B": begin
                  code = $fscanf(fd, "%h %h %h", a, b, c);
                  stalled_write(a, b, c);
               end
               "Q": begin
                  code = $fscanf(fd, "%h", a);
                  @(negedge clk);
                  check(irq, a[0], "irq level");
               end
               "N": begin
                  code = $fscanf(fd, "%h", a);
                  @(negedge clk);
                  check(rdy_in, a[0], "noc in ready level");
               end
               "T": begin
                  code = $fscanf(fd, " %s", name);
                  end_test(name);
               end
               default: begin
                  $display("unknown operation in golden file: %c", op);
                  fails++;
               end
            endcase
            if (op != "#" && op != "T") begin
               repeat (rng % 3) @(posedge clk);      // Random idle between operations
               rng = xorshift(rng);
            end
         end
      end
      if (fd != 0) begin
         $fclose(fd);
      end
      if (passes == 0) begin
         $display("no checks were run");
         fails++;
      end
      $display("summary: %0d checks passed, %0d failed", passes, fails);
      if (fails == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- compute_tile_golden.txt
# Hex fields. W port adr dat sel | R port adr exp | E port adr we | P adr0 exp0 adr1 exp1
# I type dat | O type dat | B port adr dat (stalled send) | Q irq | N noc ready | T test name
W 0 00000000 12345678 f
W 1 00000004 9abcdef0 f
R 1 00000000 12345678
R 0 00000004 9abcdef0
W 0 00000020 aabbccdd f
W 1 00000020 11223344 3
R 0 00000020 aabb3344
W 1 00000020 55667788 4
R 1 00000020 aa663344
W 0 000003fc 0badf00d f
R 1 000003fc 0badf00d
T sram_access
R 0 f0000000 18000000
R 1 f0000004 a8000000
R 0 f000003c b007c0de
R 1 f0000040 18000000
E 1 f0000008 1
R 1 f0000008 18200000
E 1 10000000 0
E 0 80000000 1
T rom_and_decode
P 00000000 12345678 00000004 9abcdef0
P f0000000 18000000 00000020 aa663344
R 1 000003fc 0badf00d
P 00000004 9abcdef0 f0000010 1860e000
T arbitration
W 1 e0000000 00000100 f
W 1 e0000004 00000101 f
W 0 e0000008 00000102 f
W 1 e000000c 00000103 f
O 0 00000100
O 1 00000101
O 2 00000102
O 3 00000103
W 1 e0000004 00000200 f
W 1 e0000000 00000201 f
W 0 e0000000 00000202 f
W 1 e0000008 00000203 f
R 0 e0000014 00000100
B 1 e000000c 00000204
O 1 00000200
O 0 00000201
O 0 00000202
O 2 00000203
O 3 00000204
T message_send
Q 0
I 1 a0000001
I 0 a0000002
I 2 a0000003
Q 1
R 1 e0000014 00000003
R 1 e0000010 a0000001
R 0 e0000010 a0000002
Q 1
R 1 e0000010 a0000003
Q 0
E 1 e0000010 0
T message_receive
I 3 b0000001
I 3 b0000002
I 3 b0000003
I 3 b0000004
N 0
R 0 e0000014 00000004
R 0 e0000010 b0000001
N 1
I 3 b0000005
R 1 e0000010 b0000002
R 1 e0000010 b0000003
R 0 e0000010 b0000004
R 1 e0000010 b0000005
Q 0
T receive_backpressure

//--- compute_tile.f
tile_pkg.sv
tile_bus.sv
tile_sram.sv
tile_bootrom.sv
tile_fifo.sv
tile_na.sv
compute_tile.sv
tb_compute_tile.sv

//--- Bender.yml
package:
  name: compute_tile

sources:
  - tile_pkg.sv
  - tile_bus.sv
  - tile_sram.sv
  - tile_bootrom.sv
  - tile_fifo.sv
  - tile_na.sv
  - compute_tile.sv
  - target: test
    files:
      - tb_compute_tile.sv
